//--- rtl/uart_tx_pkg.sv
package uart_tx_pkg;

  localparam int SETUP_W     = 31;
  localparam int BAUD_W      = 24;
  localparam int CNT_W       = 28;  // Baud field plus four bits for the sixteen-baud hold.
  localparam int BREAK_SHIFT = 4;   // One baud period times sixteen.

  // Setup word bit positions.
  localparam int SU_PAR_VAL  = 24;  // Parity sense, or the fixed parity value.
  localparam int SU_FIX_PAR  = 25;
  localparam int SU_PAR_EN   = 26;
  localparam int SU_DBL_STOP = 27;
  localparam int SU_BITS_LO  = 28;  // Two bits where 0 means 8 data bits and 3 means 5.
  localparam int SU_NO_FLOW  = 30;

  localparam int ST_W = 4;

  // The first data state depends on the word length, so shorter words
  // simply start further along the same count towards ST_BIT7.
  localparam logic [ST_W-1:0] ST_BIT0   = 4'h0;
  localparam logic [ST_W-1:0] ST_BIT1   = 4'h1;
  localparam logic [ST_W-1:0] ST_BIT2   = 4'h2;
  localparam logic [ST_W-1:0] ST_BIT3   = 4'h3;
  localparam logic [ST_W-1:0] ST_BIT7   = 4'h7;
  localparam logic [ST_W-1:0] ST_PARITY = 4'h8;
  localparam logic [ST_W-1:0] ST_STOP   = 4'h9;
  localparam logic [ST_W-1:0] ST_STOP2  = 4'ha;
  localparam logic [ST_W-1:0] ST_BREAK  = 4'he;
  localparam logic [ST_W-1:0] ST_IDLE   = 4'hf;

  // 868 clocks per baud, 8 data bits, no parity, one stop bit, flow control on.
  localparam logic [SETUP_W-1:0] INITIAL_SETUP = 31'd868;

endpackage

//--- rtl/tx_step_if.sv
`timescale 1ns/1ps

interface tx_step_if;
  import uart_tx_pkg::*;

  logic            tick;   // Baud counter is at zero.
  logic [ST_W-1:0] state;  // Frame state that changes only on tick or start.
  logic            start;  // Write accepted this cycle.
  logic            brk;
  logic            busy;

  modport timer (
    input  state,
    input  start,
    input  brk,
    output tick
  );

  modport fsm (
    input  tick,
    output state,
    output start,
    output brk,
    output busy
  );

  modport shifter (
    input  tick,
    input  state,
    input  start,
    input  brk,
    input  busy
  );

endinterface

//--- rtl/tx_baud_timer.sv
`timescale 1ns/1ps

module tx_baud_timer (
  input  logic                            i_clk,
  input  logic                            i_reset,
  input  logic [uart_tx_pkg::SETUP_W-1:0] i_setup,
  input  logic [uart_tx_pkg::BAUD_W-1:0]  i_cpb,
  input  logic                            i_dbl_stop,
  tx_step_if.timer                        step
);
  import uart_tx_pkg::*;

  logic [CNT_W-1:0] baud_cnt;
  logic [CNT_W-1:0] live_cpb;
  logic [CNT_W-1:0] reg_cpb;
  logic [CNT_W-1:0] hold_cnt;
  logic             last_stop;
  logic             tick;

  assign live_cpb = CNT_W'(i_setup[BAUD_W-1:0]);
  assign reg_cpb  = CNT_W'(i_cpb);

  // During reset the setup register sits at its default, so the
  // post-reset hold follows the word presented on the input.
  assign hold_cnt = i_reset ? (live_cpb << BREAK_SHIFT) : (reg_cpb << BREAK_SHIFT);

  assign last_stop = i_dbl_stop ? (step.state == ST_STOP2) : (step.state == ST_STOP);
  assign step.tick = tick;

  always_ff @(posedge i_clk) begin
    if (i_reset || step.brk) begin
      baud_cnt <= hold_cnt;
      tick     <= 1'b0;
    end else if (!tick) begin
      baud_cnt <= baud_cnt - CNT_W'(1);
      tick     <= (baud_cnt == CNT_W'(1));  // Tick lands on the cycle the count hits zero.
    end else if (step.state == ST_IDLE && step.start) begin
      baud_cnt <= live_cpb - CNT_W'(1);      // Start bit uses the word sampled at the write.
      tick     <= 1'b0;
    end else if (step.state == ST_IDLE || step.state == ST_BREAK) begin
      baud_cnt <= '0;                        // Park at zero with tick held high.
      tick     <= 1'b1;
    end else if (last_stop) begin
      baud_cnt <= reg_cpb - CNT_W'(2);       // Final stop bit runs one cycle short.
      tick     <= 1'b0;
    end else begin
      baud_cnt <= reg_cpb - CNT_W'(1);
      tick     <= 1'b0;
    end
  end

  a_tick_at_zero: assert property (
    @(posedge i_clk) disable iff (i_reset)
    tick == (baud_cnt == '0)
  ) else $error("baud tick out of step with the counter");

  a_count_down: assert property (
    @(posedge i_clk) disable iff (i_reset)
    !tick && !step.brk |=> baud_cnt == $past(baud_cnt) - CNT_W'(1)
  ) else $error("baud counter did not decrement");

endmodule

//--- rtl/tx_frame_fsm.sv
`timescale 1ns/1ps

module tx_frame_fsm (
  input  logic                            i_clk,
  input  logic                            i_reset,
  input  logic [uart_tx_pkg::SETUP_W-1:0] i_setup,
  input  logic                            i_break,
  input  logic                            i_wr,
  input  logic                            i_cts_n,
  output logic [uart_tx_pkg::BAUD_W-1:0]  o_cpb,
  output logic                            o_dbl_stop,
  output logic                            o_par_en,
  output logic                            o_fix_par,
  output logic                            o_par_val,
  output logic                            o_busy,
  tx_step_if.fsm                          step
);
  import uart_tx_pkg::*;

  logic [SETUP_W-1:0] r_setup;
  logic [ST_W-1:0]    state;
  logic               busy;
  logic               start;
  logic               q_cts_n;
  logic               qq_cts_n;
  logic               ck_cts;

  assign o_cpb      = r_setup[BAUD_W-1:0];
  assign o_dbl_stop = r_setup[SU_DBL_STOP];
  assign o_par_en   = r_setup[SU_PAR_EN];
  assign o_fix_par  = r_setup[SU_FIX_PAR];
  assign o_par_val  = r_setup[SU_PAR_VAL];
  assign o_busy     = busy;

  assign start      = i_wr && !busy;
  assign step.start = start;
  assign step.brk   = i_break;
  assign step.busy  = busy;
  assign step.state = state;

  // Setup is frozen for the whole frame since busy is only low while idle.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_setup <= INITIAL_SETUP;
    end else if (!busy) begin
      r_setup <= i_setup;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      q_cts_n  <= 1'b1;
      qq_cts_n <= 1'b1;
      ck_cts   <= 1'b0;
    end else begin
      q_cts_n  <= i_cts_n;
      qq_cts_n <= q_cts_n;
      ck_cts   <= !qq_cts_n || r_setup[SU_NO_FLOW];  // Clear to send.
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state <= ST_IDLE;
      busy  <= 1'b1;
    end else if (i_break) begin
      state <= ST_BREAK;
      busy  <= 1'b1;
    end else if (!step.tick) begin
      busy <= 1'b1;
    end else if (state == ST_BREAK) begin
      state <= ST_IDLE;
      busy  <= !ck_cts;
    end else if (state == ST_IDLE) begin
      if (start) begin
        busy <= 1'b1;
        case (i_setup[SU_BITS_LO +: 2])
          2'd0:    state <= ST_BIT0;
          2'd1:    state <= ST_BIT1;
          2'd2:    state <= ST_BIT2;
          default: state <= ST_BIT3;
        endcase
      end else begin
        busy <= !ck_cts;
      end
    end else if (!state[ST_W-1]) begin
      if (state == ST_BIT7) begin
        state <= o_par_en ? ST_PARITY : ST_STOP;
      end else begin
        state <= state + ST_W'(1);
      end
    end else if (state == ST_PARITY) begin
      state <= ST_STOP;
    end else if (state == ST_STOP && o_dbl_stop) begin
      state <= ST_STOP2;
    end else begin
      state <= ST_IDLE;
    end
  end

  a_legal_state: assert property (
    @(posedge i_clk) disable iff (i_reset)
    state <= ST_STOP2 || state == ST_BREAK || state == ST_IDLE
  ) else $error("frame state left the legal codes");

endmodule

//--- rtl/tx_shifter.sv
`timescale 1ns/1ps

module tx_shifter (
  input  logic                            i_clk,
  input  logic                            i_reset,
  input  logic [uart_tx_pkg::SETUP_W-1:0] i_setup,
  input  logic [7:0]                      i_data,
  input  logic                            i_fix_par,
  input  logic                            i_par_val,
  tx_step_if.shifter                      step,
  output logic                            o_uart_tx
);
  import uart_tx_pkg::*;

  logic [7:0] sh_data;
  logic       parity;
  logic       data_state;

  assign data_state = !step.state[ST_W-1];

  // Each tick puts the LSB on the line and moves the next one down.
  always_ff @(posedge i_clk) begin
    if (!step.busy) begin
      sh_data <= i_data;
    end else if (step.tick) begin
      sh_data <= {1'b0, sh_data[7:1]};
    end
  end

  always_ff @(posedge i_clk) begin
    if (!step.busy) begin
      parity <= i_setup[SU_PAR_VAL];  // Seed with the sense so odd parity needs no extra step.
    end else if (i_fix_par) begin
      parity <= i_par_val;
    end else if (step.tick && data_state) begin
      parity <= parity ^ sh_data[0];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_uart_tx <= 1'b1;
    end else if (step.brk || step.start) begin
      o_uart_tx <= 1'b0;  // Break level, or the start bit.
    end else if (step.tick) begin
      if (data_state) begin
        o_uart_tx <= sh_data[0];
      end else if (step.state == ST_PARITY) begin
        o_uart_tx <= parity;
      end else begin
        o_uart_tx <= 1'b1;
      end
    end
  end

  // Bit edges only happen on tick, so the line must be flat in between.
  a_line_steady: assert property (
    @(posedge i_clk) disable iff (i_reset)
    !step.tick && !step.start && !step.brk |=> $stable(o_uart_tx)
  ) else $error("serial line moved between bit boundaries");

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
  input  logic                            i_clk,
  input  logic                            i_reset,
  input  logic [uart_tx_pkg::SETUP_W-1:0] i_setup,
  input  logic                            i_break,
  input  logic                            i_wr,
  input  logic [7:0]                      i_data,
  input  logic                            i_cts_n,
  output logic                            o_uart_tx,
  output logic                            o_busy
);
  import uart_tx_pkg::*;

  logic [BAUD_W-1:0] cpb;
  logic              dbl_stop;
  logic              fix_par;
  logic              par_val;

  tx_step_if step ();

  tx_baud_timer u_timer (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_setup    (i_setup),
    .i_cpb      (cpb),
    .i_dbl_stop (dbl_stop),
    .step       (step.timer)
  );

  tx_frame_fsm u_fsm (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_setup    (i_setup),
    .i_break    (i_break),
    .i_wr       (i_wr),
    .i_cts_n    (i_cts_n),
    .o_cpb      (cpb),
    .o_dbl_stop (dbl_stop),
    .o_par_en   (),
    .o_fix_par  (fix_par),
    .o_par_val  (par_val),
    .o_busy     (o_busy),
    .step       (step.fsm)
  );

  tx_shifter u_shifter (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_setup   (i_setup),
    .i_data    (i_data),
    .i_fix_par (fix_par),
    .i_par_val (par_val),
    .step      (step.shifter),
    .o_uart_tx (o_uart_tx)
  );

endmodule

//--- dv/tx_line_monitor.sv
`timescale 1ns/1ps

module tx_line_monitor (
  input  logic                            i_clk,
  input  logic                            i_reset,
  input  logic [uart_tx_pkg::SETUP_W-1:0] i_setup,
  input  logic [7:0]                      i_data,
  input  logic                            i_wr,
  input  logic                            i_break,
  input  logic                            i_uart_tx,
  input  logic                            i_busy,
  output int                              o_err_cnt,
  output int                              o_frame_cnt
);
  import uart_tx_pkg::*;

  int err_cnt = 0;
  int frame_cnt = 0;

  assign o_err_cnt   = err_cnt;
  assign o_frame_cnt = frame_cnt;

  task automatic check_bit(input string name, input logic expected);
    assert (i_uart_tx === expected) else begin
      err_cnt++;
      $display("FAIL t=%0t o_uart_tx (%s): expected %b, actual %b",
               $time, name, expected, i_uart_tx);
    end
  endtask

  // Bit k of a frame covers negedges k*cpb to k*cpb+cpb-1 after the start edge.
  task automatic check_frame(input logic [SETUP_W-1:0] setup, input logic [7:0] data);
    int   cpb;
    int   nbits;
    logic par;
    cpb   = int'(setup[BAUD_W-1:0]);
    nbits = 8 - int'(setup[SU_BITS_LO +: 2]);
    par   = setup[SU_PAR_VAL];
    @(negedge i_clk);
    check_bit("start edge", 1'b0);
    repeat (cpb / 2) @(negedge i_clk);
    check_bit("start", 1'b0);
    for (int i = 0; i < nbits; i++) begin
      repeat (cpb) @(negedge i_clk);
      check_bit($sformatf("data%0d", i), data[i]);
      par = par ^ data[i];
    end
    if (setup[SU_PAR_EN]) begin
      repeat (cpb) @(negedge i_clk);
      check_bit("parity", setup[SU_FIX_PAR] ? setup[SU_PAR_VAL] : par);
    end
    repeat (cpb) @(negedge i_clk);
    check_bit("stop", 1'b1);
    if (setup[SU_DBL_STOP]) begin
      repeat (cpb) @(negedge i_clk);
      check_bit("stop2", 1'b1);
    end
    frame_cnt++;
  endtask

  initial begin
    forever begin
      @(posedge i_clk);
      if (!i_reset && i_wr && !i_busy) begin
        check_frame(i_setup, i_data);  // Setup and data as seen at the accepting edge.
      end
    end
  end

  a_start_follows_write: assert property (
    @(posedge i_clk) disable iff (i_reset)
    i_wr && !i_busy && !i_break |=> !i_uart_tx && i_busy
  ) else begin
    err_cnt++;
    $display("FAIL t=%0t o_uart_tx/o_busy after write: expected 0/1, actual %b/%b",
             $time, $sampled(i_uart_tx), $sampled(i_busy));
  end

  a_break_low: assert property (
    @(posedge i_clk) disable iff (i_reset)
    i_break |=> !i_uart_tx
  ) else begin
    err_cnt++;
    $display("FAIL t=%0t o_uart_tx during break: expected 0, actual %b",
             $time, $sampled(i_uart_tx));
  end

  a_no_stray_start: assert property (
    @(posedge i_clk) disable iff (i_reset)
    $fell(i_uart_tx) && !$past(i_busy) |-> $past(i_wr) || $past(i_break)
  ) else begin
    err_cnt++;
    $display("Error at %0t: the line fell with no accepted write and no break", $time);
  end

endmodule

//--- dv/tb_uart_tx.sv
`timescale 1ns/1ps

module tb_uart_tx;
  import uart_tx_pkg::*;

  localparam int MAX_CPB  = 12;
  localparam int N_FRAMES = 18;
  // Thirteen bauds per frame plus two break holds and the reset hold, with 20 percent margin.
  localparam int TIMEOUT_CYCLES = (N_FRAMES * 13 + 3 * 16) * MAX_CPB * 6 / 5;

  logic               i_clk;
  logic               i_reset;
  logic [SETUP_W-1:0] i_setup;
  logic               i_break;
  logic               i_wr;
  logic [7:0]         i_data;
  logic               i_cts_n;
  logic               o_uart_tx;
  logic               o_busy;
  int                 mon_err_cnt;
  int                 frame_cnt;
  int                 tb_err_cnt = 0;
  int                 cycle_cnt = 0;
  logic [31:0]        lcg_state = 32'd47;

  uart_tx uart_tx_inst (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_setup   (i_setup),
    .i_break   (i_break),
    .i_wr      (i_wr),
    .i_data    (i_data),
    .i_cts_n   (i_cts_n),
    .o_uart_tx (o_uart_tx),
    .o_busy    (o_busy)
  );

  tx_line_monitor line_mon (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_setup     (i_setup),
    .i_data      (i_data),
    .i_wr        (i_wr),
    .i_break     (i_break),
    .i_uart_tx   (o_uart_tx),
    .i_busy      (o_busy),
    .o_err_cnt   (mon_err_cnt),
    .o_frame_cnt (frame_cnt)
  );

  initial i_clk = 1'b0;
  always #10 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [7:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];
  endfunction

  function automatic logic [SETUP_W-1:0] build_setup(input int cpb, input int bits_code,
      input logic par_en, input logic fix_par, input logic par_val, input logic dbl_stop,
      input logic no_flow);
    logic [SETUP_W-1:0] s;
    s                  = '0;
    s[BAUD_W-1:0]      = BAUD_W'(cpb);
    s[SU_BITS_LO +: 2] = 2'(bits_code);
    s[SU_PAR_EN]       = par_en;
    s[SU_FIX_PAR]      = fix_par;
    s[SU_PAR_VAL]      = par_val;
    s[SU_DBL_STOP]     = dbl_stop;
    s[SU_NO_FLOW]      = no_flow;
    return s;
  endfunction

  task automatic report_mismatch(input string name, input logic expected, input logic actual);
    tb_err_cnt++;
    $display("FAIL t=%0t %s: expected %b, actual %b", $time, name, expected, actual);
  endtask

  task automatic wait_idle();
    while (o_busy) @(negedge i_clk);
  endtask

  // Called on a falling edge. Holds i_wr until the DUT takes the byte.
  task automatic send_byte(input logic [SETUP_W-1:0] setup, input logic [7:0] data);
    i_setup = setup;
    i_data  = data;
    i_wr    = 1'b1;
    wait_idle();
    @(negedge i_clk);
    i_wr = 1'b0;
  endtask

  task automatic check_flow();
    wait_idle();
    i_setup = build_setup(8, 0, 0, 0, 0, 0, 0);
    i_cts_n = 1'b1;
    repeat (6) @(negedge i_clk);
    i_data = next_rand();
    i_wr   = 1'b1;
    repeat (40) begin
      @(negedge i_clk);
      assert (o_busy === 1'b1) else report_mismatch("o_busy while CTS off", 1'b1, o_busy);
      assert (o_uart_tx === 1'b1) else report_mismatch("o_uart_tx while CTS off", 1'b1, o_uart_tx);
    end
    i_cts_n = 1'b0;  // The held write goes out once the synchronizer sees CTS.
    send_byte(i_setup, i_data);
    wait_idle();
    i_setup = build_setup(8, 0, 0, 0, 0, 0, 1);
    repeat (2) @(negedge i_clk);
    i_cts_n = 1'b1;
    repeat (6) @(negedge i_clk);
    assert (o_busy === 1'b0) else report_mismatch("o_busy with flow control off", 1'b0, o_busy);
    send_byte(build_setup(8, 0, 0, 0, 0, 0, 1), next_rand());
    wait_idle();
    i_cts_n = 1'b0;
  endtask

  task automatic check_break(input int cpb);
    int low_cnt;
    low_cnt = 0;
    wait_idle();
    i_setup = build_setup(cpb, 0, 0, 0, 0, 0, 0);
    repeat (2) @(negedge i_clk);
    i_break = 1'b1;
    repeat (30) begin
      @(negedge i_clk);
      assert (o_uart_tx === 1'b0) else report_mismatch("o_uart_tx in break", 1'b0, o_uart_tx);
    end
    i_break = 1'b0;
    @(negedge i_clk);
    while (!o_uart_tx && low_cnt < 16 * cpb + 8) begin
      low_cnt++;
      @(negedge i_clk);
    end
    assert (low_cnt >= 16 * cpb) else begin
      tb_err_cnt++;
      $display("Error at %0t: break hold lasted %0d cycles, shorter than %0d",
               $time, low_cnt, 16 * cpb);
    end
    assert (o_uart_tx === 1'b1) else report_mismatch("o_uart_tx after break", 1'b1, o_uart_tx);
    wait_idle();
  endtask

  initial begin
    i_reset = 1'b1;
    i_break = 1'b0;
    i_wr    = 1'b0;
    i_cts_n = 1'b0;
    i_data  = 8'h00;
    i_setup = build_setup(8, 0, 0, 0, 0, 0, 0);
    repeat (10) @(negedge i_clk);
    i_reset = 1'b0;
    @(negedge i_clk);
    assert (o_busy === 1'b1) else report_mismatch("o_busy after reset", 1'b1, o_busy);
    assert (o_uart_tx === 1'b1) else report_mismatch("o_uart_tx after reset", 1'b1, o_uart_tx);

    repeat (6) send_byte(build_setup(8, 0, 0, 0, 0, 0, 0), next_rand());
    for (int code = 1; code <= 3; code++) begin
      send_byte(build_setup(8 + code, code, 1, 0, 0, 0, 0), next_rand());
      send_byte(build_setup(8 + code, code, 1, 0, 1, 0, 0), next_rand());
    end
    send_byte(build_setup(12, 0, 1, 1, 0, 1, 0), next_rand());
    send_byte(build_setup(12, 0, 1, 1, 1, 1, 0), next_rand());

    check_flow();
    check_break(8);
    check_break(12);

    // The setup moves under a running frame; only the next frame sees it.
    send_byte(build_setup(10, 0, 1, 0, 0, 0, 0), next_rand());
    repeat (30) @(negedge i_clk);
    i_setup = build_setup(11, 3, 1, 1, 1, 1, 0);
    repeat (30) @(negedge i_clk);
    send_byte(build_setup(9, 2, 1, 0, 1, 1, 0), next_rand());
    wait_idle();
    repeat (4) @(negedge i_clk);

    assert (frame_cnt == N_FRAMES) else begin
      tb_err_cnt++;
      $display("Error: the monitor checked %0d frames instead of %0d", frame_cnt, N_FRAMES);
    end
    $display("Errors: monitor %0d, testbench %0d, frames checked %0d",
             mon_err_cnt, tb_err_cnt, frame_cnt);
    if (mon_err_cnt == 0 && tb_err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- flist.f
rtl/uart_tx_pkg.sv
rtl/tx_step_if.sv
rtl/tx_baud_timer.sv
rtl/tx_frame_fsm.sv
rtl/tx_shifter.sv
rtl/uart_tx.sv
dv/tx_line_monitor.sv
dv/tb_uart_tx.sv

//--- Bender.yml
package:
  name: uart_tx

dependencies: {}

sources:
  - rtl/uart_tx_pkg.sv
  - rtl/tx_step_if.sv
  - rtl/tx_baud_timer.sv
  - rtl/tx_frame_fsm.sv
  - rtl/tx_shifter.sv
  - rtl/uart_tx.sv

  - target: test
    files:
      - dv/tx_line_monitor.sv
      - dv/tb_uart_tx.sv
